/* stall_pkg.sv */
// Stall modes and configuration word; a zero seed locks the LFSR, so random mode needs a nonzero seed
package stall_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and LFSR constants
    //////////////////////////////////////////////////////////////////////

    // Width of one stall count, also the LFSR width
    localparam int STALL_W = 16;

    // Galois taps for x^16 + x^14 + x^13 + x^11 + 1, right shifting
    localparam logic [STALL_W-1:0] LFSR_TAPS = 16'hB400;

    // Mixed into the response seed so both timers draw different sequences
    localparam logic [STALL_W-1:0] RESP_SEED_MIX = 16'h5A3C;

    //////////////////////////////////////////////////////////////////////
    // Mode and configuration types
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        STALL_OFF    = 2'd0,
        STALL_FIXED  = 2'd1,
        STALL_RANDOM = 2'd2
    } stall_mode_e;

    // Same 32-bit word, read per mode
    // Upper half is grant stalls or the limit, lower half valid stalls or the seed
    typedef union packed {
        struct packed {
            logic [STALL_W-1:0] gnt_stalls;
            logic [STALL_W-1:0] valid_stalls;
        } fixed_v;
        struct packed {
            logic [STALL_W-1:0] max_stalls;
            logic [STALL_W-1:0] seed;
        } random_v;
    } stall_cfg_u;

endpackage

/* mem_bus_pkg.sv */
// Bus widths and response buffer sizing; CNT_W must be able to hold FIFO_DEPTH itself
package mem_bus_pkg;

    // Load/store bus fields
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    //////////////////////////////////////////////////////////////////////
    // Response buffer
    //////////////////////////////////////////////////////////////////////

    // Entries in the response FIFO, a power of two
    localparam int FIFO_DEPTH = 4;

    // Index width into the FIFO
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Outstanding count, 0 up to FIFO_DEPTH inclusive
    localparam int CNT_W = 3;

endpackage

/* stall_timer.sv */
// Stall down-counter; zero_o is combinational in the load cycle, and a zero seed stalls the LFSR
`timescale 1ns/1ps

module stall_timer (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  stall_pkg::stall_mode_e        mode_i,
    input  logic [stall_pkg::STALL_W-1:0] cfg_count_i,
    input  logic [stall_pkg::STALL_W-1:0] seed_i,
    input  logic [stall_pkg::STALL_W-1:0] max_i,
    input  logic                          load_i,
    output logic                          zero_o
);
    import stall_pkg::*;

    logic [STALL_W-1:0] count_q;
    logic [STALL_W-1:0] lfsr_q;
    logic [STALL_W-1:0] lfsr_next;
    logic [STALL_W-1:0] mask;
    logic [STALL_W-1:0] masked;
    logic [STALL_W-1:0] draw;
    logic [STALL_W-1:0] load_val;
    logic               load_zero;

    // Galois step, shift right and fold taps in on a one
    assign lfsr_next = {1'b0, lfsr_q[STALL_W-1:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);

    // Smallest all-ones mask covering max_i
    always_comb begin
        mask = '0;
        for (int i = 0; i < STALL_W; i++) begin
            mask[i] = |(max_i >> i);
        end
    end

    // Masked draw is at most 2*max+1, so one fold lands it in 0..max
    assign masked = lfsr_q & mask;
    assign draw   = (masked > max_i) ? (masked - max_i - 1'b1) : masked;

    always_comb begin
        case (mode_i)
            STALL_FIXED:  load_val = cfg_count_i;
            STALL_RANDOM: load_val = draw;
            default:      load_val = '0;
        endcase
    end

    assign load_zero = (load_val == '0);

    //////////////////////////////////////////////////////////////////////
    // Counter
    //////////////////////////////////////////////////////////////////////

    // Load cycle is the first stall cycle, hence the minus one
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_zero ? '0 : load_val - 1'b1;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // One LFSR step per random draw only
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lfsr_q <= seed_i;
        end else if (load_i && (mode_i == STALL_RANDOM)) begin
            lfsr_q <= lfsr_next;
        end
    end

    // Zero stalls release in the same cycle as the load
    assign zero_o = load_i ? load_zero : (count_q == '0);

endmodule

/* req_stall_path.sv */
// Request stall path; assumes req stays high with stable fields until its grant cycle
`timescale 1ns/1ps

module req_stall_path (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  stall_pkg::stall_mode_e mode_i,
    input  stall_pkg::stall_cfg_u  cfg_i,
    input  logic                   req_core_i,
    input  logic                   room_i,
    input  logic                   gnt_mem_i,
    output logic                   req_mem_o,
    output logic                   gnt_core_o,
    output logic                   grant_o
);

    logic pending_q;
    logic start;
    logic stall_done;
    logic grant;

    // First cycle of a request, nothing loaded yet
    assign start = req_core_i & ~pending_q;

    stall_timer gnt_timer_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mode_i      (mode_i),
        .cfg_count_i (cfg_i.fixed_v.gnt_stalls),
        .seed_i      (cfg_i.random_v.seed),
        .max_i       (cfg_i.random_v.max_stalls),
        .load_i      (start),
        .zero_o      (stall_done)
    );

    // Held back while stalling or while the tracker is full
    assign req_mem_o = req_core_i & room_i & stall_done;

    // Grant cycle seen by both sides
    assign grant      = req_mem_o & gnt_mem_i;
    assign gnt_core_o = grant;
    assign grant_o    = grant;

    // Set on load, cleared by the grant, so a back-to-back request reloads
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else if (grant) begin
            pending_q <= 1'b0;
        end else if (start) begin
            pending_q <= 1'b1;
        end
    end

endmodule

/* resp_stall_path.sv */
// Response stall FIFO; no full check, overflow is prevented upstream by the transaction tracker
`timescale 1ns/1ps

module resp_stall_path (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  stall_pkg::stall_mode_e         mode_i,
    input  stall_pkg::stall_cfg_u          cfg_i,
    input  logic                           rvalid_mem_i,
    input  logic [mem_bus_pkg::DATA_W-1:0] rdata_mem_i,
    output logic                           rvalid_core_o,
    output logic [mem_bus_pkg::DATA_W-1:0] rdata_core_o,
    output logic                           pop_o
);
    import stall_pkg::*;
    import mem_bus_pkg::*;

    logic [DATA_W-1:0] fifo_q [FIFO_DEPTH];
    // Extra MSB tells full from empty
    logic [PTR_W:0]    wptr_q;
    logic [PTR_W:0]    rptr_q;
    logic              empty;
    logic              armed_q;
    logic              load_head;
    logic              head_ready;
    logic              pop;
    logic [STALL_W-1:0] resp_seed;

    assign empty = (wptr_q == rptr_q);

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rvalid_mem_i) begin
            fifo_q[wptr_q[PTR_W-1:0]] <= rdata_mem_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (rvalid_mem_i) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Head release timing
    //////////////////////////////////////////////////////////////////////

    // Different seed from the grant timer
    assign resp_seed = cfg_i.random_v.seed ^ RESP_SEED_MIX;

    // A head that has not been timed yet
    assign load_head = ~empty & ~armed_q;

    stall_timer valid_timer_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mode_i      (mode_i),
        .cfg_count_i (cfg_i.fixed_v.valid_stalls),
        .seed_i      (resp_seed),
        .max_i       (cfg_i.random_v.max_stalls),
        .load_i      (load_head),
        .zero_o      (head_ready)
    );

    assign pop = ~empty & head_ready;

    // Armed until popped, then the next head gets a fresh stall
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= ~empty & ~pop;
        end
    end

    // One-cycle strobe per entry, data straight from the head
    assign rvalid_core_o = pop;
    assign rdata_core_o  = fifo_q[rptr_q[PTR_W-1:0]];
    assign pop_o         = pop;

endmodule

/* txn_tracker.sv */
// Outstanding transaction counter; room is taken from the registered count, so a same-cycle pop does not free it
`timescale 1ns/1ps

module txn_tracker (
    input  logic clk_i,
    input  logic rst_i,
    input  logic grant_i,
    input  logic pop_i,
    output logic room_o
);
    import mem_bus_pkg::*;

    // Granted but not yet returned to the core
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else begin
            case ({grant_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                // Both or neither leave it unchanged
                default: count_q <= count_q;
            endcase
        end
    end

    // Every counted transaction may still need a FIFO slot
    assign room_o = (count_q < CNT_W'(FIFO_DEPTH));

endmodule

/* mem_stall_unit.sv */
// Stall injector top; in-order memory only, and stall_mode_i and stall_cfg_i stay static while requests are active
`timescale 1ns/1ps

module mem_stall_unit (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  stall_pkg::stall_mode_e         stall_mode_i,
    input  stall_pkg::stall_cfg_u          stall_cfg_i,
    // Core side
    input  logic                           req_core_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] addr_core_i,
    input  logic                           we_core_i,
    input  logic [mem_bus_pkg::BE_W-1:0]   be_core_i,
    input  logic [mem_bus_pkg::DATA_W-1:0] wdata_core_i,
    output logic                           gnt_core_o,
    output logic                           rvalid_core_o,
    output logic [mem_bus_pkg::DATA_W-1:0] rdata_core_o,
    // Memory side
    output logic                           req_mem_o,
    output logic [mem_bus_pkg::ADDR_W-1:0] addr_mem_o,
    output logic                           we_mem_o,
    output logic [mem_bus_pkg::BE_W-1:0]   be_mem_o,
    output logic [mem_bus_pkg::DATA_W-1:0] wdata_mem_o,
    input  logic                           gnt_mem_i,
    input  logic                           rvalid_mem_i,
    input  logic [mem_bus_pkg::DATA_W-1:0] rdata_mem_i
);

    logic room;
    logic grant;
    logic pop;

    // Fields need no delay, only req is held back
    assign addr_mem_o  = addr_core_i;
    assign we_mem_o    = we_core_i;
    assign be_mem_o    = be_core_i;
    assign wdata_mem_o = wdata_core_i;

    req_stall_path req_stall_path_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mode_i     (stall_mode_i),
        .cfg_i      (stall_cfg_i),
        .req_core_i (req_core_i),
        .room_i     (room),
        .gnt_mem_i  (gnt_mem_i),
        .req_mem_o  (req_mem_o),
        .gnt_core_o (gnt_core_o),
        .grant_o    (grant)
    );

    resp_stall_path resp_stall_path_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mode_i        (stall_mode_i),
        .cfg_i         (stall_cfg_i),
        .rvalid_mem_i  (rvalid_mem_i),
        .rdata_mem_i   (rdata_mem_i),
        .rvalid_core_o (rvalid_core_o),
        .rdata_core_o  (rdata_core_o),
        .pop_o         (pop)
    );

    // Closes the loop between grants and released responses
    txn_tracker txn_tracker_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .grant_i (grant),
        .pop_i   (pop),
        .room_o  (room)
    );

endmodule

/* mem_stall_checker.sv */
// Bus protocol assertions bound into the stall unit; counts assume single-beat in-order responses
`timescale 1ns/1ps

module mem_stall_checker (
    input logic                           clk_i,
    input logic                           rst_i,
    input logic                           req_mem_i,
    input logic                           gnt_mem_i,
    input logic [mem_bus_pkg::ADDR_W-1:0] addr_mem_i,
    input logic                           we_mem_i,
    input logic [mem_bus_pkg::BE_W-1:0]   be_mem_i,
    input logic [mem_bus_pkg::DATA_W-1:0] wdata_mem_i,
    input logic                           gnt_core_i,
    input logic                           rvalid_core_i
);
    import mem_bus_pkg::*;

    // Granted transactions still owed a core response
    logic [7:0] open_q;

    // Failure tallies per property
    int stable_fails = 0;
    int order_fails  = 0;
    int room_fails   = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            open_q <= '0;
        end else if (gnt_core_i && !rvalid_core_i) begin
            open_q <= open_q + 8'd1;
        end else if (!gnt_core_i && rvalid_core_i) begin
            open_q <= open_q - 8'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////////////////////////

    // Request and its fields hold until memory grants
    held_until_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_mem_i && !gnt_mem_i) |=> (req_mem_i && $stable(addr_mem_i) && $stable(we_mem_i)
            && $stable(be_mem_i) && $stable(wdata_mem_i)))
    else begin
        stable_fails++;
        $error("memory request dropped or changed before its grant");
    end

    // Grant and its response never share a cycle, so the old count is enough
    resp_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_core_i |-> (open_q != 8'd0))
    else begin
        order_fails++;
        $error("core response without an open granted transaction");
    end

    // Every response buffer slot taken, so no new memory request
    blocked_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
        (open_q >= 8'(FIFO_DEPTH)) |-> !req_mem_i)
    else begin
        room_fails++;
        $error("memory request while the tracker is full");
    end

endmodule

bind mem_stall_unit mem_stall_checker mem_stall_checker_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_mem_i     (req_mem_o),
    .gnt_mem_i     (gnt_mem_i),
    .addr_mem_i    (addr_mem_o),
    .we_mem_i      (we_mem_o),
    .be_mem_i      (be_mem_o),
    .wdata_mem_i   (wdata_mem_o),
    .gnt_core_i    (gnt_core_o),
    .rvalid_core_i (rvalid_core_o)
);

/* tb_mem_stall_unit.sv */
// Self-checking testbench; the memory grants after a per-row delay and answers in order 2 cycles after each grant
`timescale 1ns/1ps

module tb_mem_stall_unit;
    import stall_pkg::*;
    import mem_bus_pkg::*;

    localparam logic [31:0] RND_SEED = 32'h6c00_5fb7;
    // Memory read data is the address with this key folded in
    localparam logic [DATA_W-1:0] DATA_KEY = 32'hC0DE_5A5A;
    // Delay that depends on queueing, left unchecked
    localparam int SKIP = -1;

    logic              clk_i;
    logic              rst_i;
    stall_mode_e       stall_mode_i;
    stall_cfg_u        stall_cfg_i;
    logic              req_core_i;
    logic [ADDR_W-1:0] addr_core_i;
    logic              we_core_i;
    logic [BE_W-1:0]   be_core_i;
    logic [DATA_W-1:0] wdata_core_i;
    logic              gnt_core_o;
    logic              rvalid_core_o;
    logic [DATA_W-1:0] rdata_core_o;
    logic              req_mem_o;
    logic [ADDR_W-1:0] addr_mem_o;
    logic              we_mem_o;
    logic [BE_W-1:0]   be_mem_o;
    logic [DATA_W-1:0] wdata_mem_o;
    logic              gnt_mem_i;
    logic              rvalid_mem_i;
    logic [DATA_W-1:0] rdata_mem_i;

    // Stimulus table, one transaction per row
    stall_mode_e       t_mode[$];
    logic [31:0]       t_cfg[$];
    logic [ADDR_W-1:0] t_addr[$];
    logic              t_we[$];
    int                t_mem_dly[$];
    logic              t_chain[$];
    int                t_exp_gnt[$];
    int                t_exp_resp[$];

    int cyc = 0;
    int cycle_limit = 100000;
    int errors = 0;
    int grant_cnt = 0;
    int resp_cnt = 0;
    int cur_row = 0;
    int mon_row;
    int mon_cyc;
    // Memory model state
    int mem_gnt_delay = 0;
    int mem_wait = 0;
    logic gnt_next;
    int mem_due_q[$];
    logic [DATA_W-1:0] mem_data_q[$];
    // Granted rows in order, and the cycles of their memory responses
    int exp_row_q[$];
    int mem_rv_q[$];

    mem_stall_unit mem_stall_unit_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_mode_i (stall_mode_i),
        .stall_cfg_i  (stall_cfg_i),
        .req_core_i   (req_core_i),
        .addr_core_i  (addr_core_i),
        .we_core_i    (we_core_i),
        .be_core_i    (be_core_i),
        .wdata_core_i (wdata_core_i),
        .gnt_core_o   (gnt_core_o),
        .rvalid_core_o(rvalid_core_o),
        .rdata_core_o (rdata_core_o),
        .req_mem_o    (req_mem_o),
        .addr_mem_o   (addr_mem_o),
        .we_mem_o     (we_mem_o),
        .be_mem_o     (be_mem_o),
        .wdata_mem_o  (wdata_mem_o),
        .gnt_mem_i    (gnt_mem_i),
        .rvalid_mem_i (rvalid_mem_i),
        .rdata_mem_i  (rdata_mem_i)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic add_row(input stall_mode_e mode, input logic [31:0] cfg,
                           input logic [ADDR_W-1:0] addr, input logic we, input int mem_dly,
                           input logic chain, input int exp_gnt, input int exp_resp);
        t_mode.push_back(mode);
        t_cfg.push_back(cfg);
        t_addr.push_back(addr);
        t_we.push_back(we);
        t_mem_dly.push_back(mem_dly);
        t_chain.push_back(chain);
        t_exp_gnt.push_back(exp_gnt);
        t_exp_resp.push_back(exp_resp);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Random rows give a limit, other rows the exact delay
    task automatic check_delay(input string name, input int got, input int exp,
                               input stall_mode_e mode);
        if (exp == SKIP) begin
            return;
        end
        if (mode == STALL_RANDOM) begin
            if (got > exp) begin
                check_value({name, " over limit"}, got, exp);
            end
        end else begin
            check_value(name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, cycle count and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk_i) begin
        if (cyc > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    // Decide at mid-cycle, drive just after the next rising edge
    initial begin
        gnt_mem_i = 1'b0;
        rvalid_mem_i = 1'b0;
        rdata_mem_i = '0;
        forever begin
            @(negedge clk_i);
            if (rst_i) begin
                mem_wait = 0;
            end else if (req_mem_o && gnt_mem_i) begin
                mem_due_q.push_back(cyc + 2);
                mem_data_q.push_back(addr_mem_o ^ DATA_KEY);
                mem_wait = 0;
            end else if (req_mem_o) begin
                mem_wait++;
            end
            // A zero delay memory is ready before the request arrives
            gnt_next = !rst_i && (mem_wait >= mem_gnt_delay);
            @(posedge clk_i);
            #2;
            gnt_mem_i = gnt_next;
            if (mem_due_q.size() != 0 && mem_due_q[0] == cyc) begin
                rvalid_mem_i = 1'b1;
                rdata_mem_i = mem_data_q.pop_front();
                void'(mem_due_q.pop_front());
            end else begin
                rvalid_mem_i = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Grant and response monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (gnt_core_o) begin
                grant_cnt++;
                exp_row_q.push_back(cur_row);
            end
            if (rvalid_mem_i) begin
                mem_rv_q.push_back(cyc);
            end
            if (rvalid_core_o) begin
                resp_cnt++;
                if (exp_row_q.size() == 0 || mem_rv_q.size() == 0) begin
                    errors++;
                    $display("core response arrived with no granted request behind it");
                end else begin
                    mon_row = exp_row_q.pop_front();
                    mon_cyc = mem_rv_q.pop_front();
                    // In order, so the head row owns this data
                    check_value("rdata_core_o", rdata_core_o, t_addr[mon_row] ^ DATA_KEY);
                    check_delay("rvalid_core_o delay", cyc - mon_cyc, t_exp_resp[mon_row],
                                t_mode[mon_row]);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int r;
        int req_cyc;
        int budget;
        int assert_fails;
        logic granted;
        logic [31:0] rnd;

        rst_i = 1'b1;
        stall_mode_i = STALL_OFF;
        // Seed is taken by both LFSRs during reset
        stall_cfg_i = 32'h0007_ACE1;
        req_core_i = 1'b0;
        addr_core_i = '0;
        we_core_i = 1'b0;
        be_core_i = '0;
        wdata_core_i = '0;
        rnd = $urandom(RND_SEED);

        // Mode, config, address, write, memory grant delay, chained, grant delay, resp delay
        add_row(STALL_OFF,    32'h0000_0000, 32'h0000_0100, 1'b0, 0, 1'b0, 0, 1);
        add_row(STALL_OFF,    32'h0000_0000, 32'h0000_0104, 1'b1, 0, 1'b0, 0, 1);
        // Fixed view, gnt_stalls high and valid_stalls low
        add_row(STALL_FIXED,  32'h0003_0004, 32'h0000_0200, 1'b0, 0, 1'b0, 3, 5);
        add_row(STALL_FIXED,  32'h0000_0000, 32'h0000_0204, 1'b0, 0, 1'b0, 0, 1);
        add_row(STALL_FIXED,  32'h0002_0001, 32'h0000_0208, 1'b1, 0, 1'b0, 2, 2);
        // Memory holds back its grant
        add_row(STALL_OFF,    32'h0000_0000, 32'h0000_0300, 1'b0, 3, 1'b0, 3, 1);
        add_row(STALL_FIXED,  32'h0001_0002, 32'h0000_0304, 1'b1, 2, 1'b0, 3, 3);
        // Random view, max_stalls 7, limits are 7 plus memory delay and 1 plus 7
        add_row(STALL_RANDOM, 32'h0007_ACE1, 32'h0000_0400, 1'b0, 1, 1'b0, 8, 8);
        add_row(STALL_RANDOM, 32'h0007_ACE1, 32'h0000_0404, 1'b1, 1, 1'b0, 8, 8);
        add_row(STALL_RANDOM, 32'h0007_ACE1, 32'h0000_0408, 1'b0, 1, 1'b0, 8, 8);
        add_row(STALL_RANDOM, 32'h0007_ACE1, 32'h0000_040C, 1'b0, 1, 1'b0, 8, 8);
        // Back-to-back burst, the fifth request waits on the tracker
        add_row(STALL_FIXED,  32'h0000_0006, 32'h0000_0500, 1'b1, 0, 1'b0, 0, 7);
        add_row(STALL_FIXED,  32'h0000_0006, 32'h0000_0504, 1'b0, 0, 1'b1, 0, SKIP);
        add_row(STALL_FIXED,  32'h0000_0006, 32'h0000_0508, 1'b1, 0, 1'b1, 0, SKIP);
        add_row(STALL_FIXED,  32'h0000_0006, 32'h0000_050C, 1'b0, 0, 1'b1, 0, SKIP);
        add_row(STALL_FIXED,  32'h0000_0006, 32'h0000_0510, 1'b0, 0, 1'b1, SKIP, SKIP);
        add_row(STALL_FIXED,  32'h0000_0006, 32'h0000_0514, 1'b0, 0, 1'b1, SKIP, SKIP);

        // Worst case per row, unchecked delays get a generous share
        budget = 16 + 64;
        for (r = 0; r < t_addr.size(); r++) begin
            budget += (t_exp_gnt[r] == SKIP) ? 24 : t_exp_gnt[r];
            budget += (t_exp_resp[r] == SKIP) ? 24 : t_exp_resp[r];
            budget += 4;
        end
        cycle_limit = budget;

        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        for (r = 0; r < t_addr.size(); r++) begin
            // Idle cycle lets the new config and memory delay settle
            if (!t_chain[r]) begin
                stall_mode_i = t_mode[r];
                stall_cfg_i = t_cfg[r];
                mem_gnt_delay = t_mem_dly[r];
                @(posedge clk_i);
                #2;
            end
            rnd = $urandom();
            wdata_core_i = rnd;
            rnd = $urandom();
            be_core_i = t_we[r] ? rnd[BE_W-1:0] : '1;
            addr_core_i = t_addr[r];
            we_core_i = t_we[r];
            req_core_i = 1'b1;
            cur_row = r;
            req_cyc = cyc;

            // Fields at memory must not move while the grant is pending
            granted = 1'b0;
            while (!granted) begin
                @(negedge clk_i);
                check_value("addr_mem_o", addr_mem_o, t_addr[r]);
                check_value("we_mem_o", {31'b0, we_mem_o}, {31'b0, t_we[r]});
                check_value("be_mem_o", {28'b0, be_mem_o}, {28'b0, be_core_i});
                check_value("wdata_mem_o", wdata_mem_o, wdata_core_i);
                granted = gnt_core_o;
            end
            check_delay("gnt_core_o delay", cyc - req_cyc, t_exp_gnt[r], t_mode[r]);

            @(posedge clk_i);
            #2;
            if (!(r + 1 < t_addr.size() && t_chain[r + 1])) begin
                req_core_i = 1'b0;
                while (exp_row_q.size() != 0) begin
                    @(posedge clk_i);
                    #2;
                end
            end
        end

        // Exactly one grant and one response per row
        check_value("gnt_core_o count", grant_cnt, t_addr.size());
        check_value("rvalid_core_o count", resp_cnt, t_addr.size());
        assert_fails = mem_stall_unit_inst.mem_stall_checker_inst.stable_fails
                     + mem_stall_unit_inst.mem_stall_checker_inst.order_fails
                     + mem_stall_unit_inst.mem_stall_checker_inst.room_fails;
        $display("errors: %0d check, %0d assertion", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
stall_pkg.sv
mem_bus_pkg.sv
stall_timer.sv
req_stall_path.sv
resp_stall_path.sv
txn_tracker.sv
mem_stall_unit.sv
mem_stall_checker.sv
tb_mem_stall_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stall_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
